//--- axi/axi_reg_bank.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module axi_reg_bank (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  axi_regs_pkg::axi_addr_t awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  axi_regs_pkg::axi_data_t wdata,
  input  axi_regs_pkg::axi_strb_t wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output axi_regs_pkg::axi_resp_t bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  axi_regs_pkg::axi_addr_t araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output axi_regs_pkg::axi_data_t rdata,
  output axi_regs_pkg::axi_resp_t rresp,
  output logic                    rvalid,
  input  logic                    rready,
  input  logic                    fifo_full,
  output logic                    tri_push,
  output raster_pkg::triangle_t   tri_data
);

  import axi_regs_pkg::*;
  import raster_pkg::*;

  axi_data_t  regs [`REG_COUNT];
  // shared pulse for awready and wready
  logic       accept_q;
  // low while a write response is outstanding
  logic       aw_en;
  logic       wr_en;
  logic       push_now;
  reg_index_t wr_idx;
  triangle_t  packed_tri;

  assign awready = accept_q;
  assign wready  = accept_q;
  assign bresp   = RESP_OKAY;
  assign rresp   = RESP_OKAY;

  // master holds address and data until ready, so index straight off the bus
  assign wr_idx   = awaddr[4:2];
  assign wr_en    = accept_q && awvalid && wvalid;
  assign push_now = wr_en && (wr_idx == reg_index_t'(`REG_PUSH_INDEX)) && !fifo_full;

  // ----------------------------------------
  // write channel
  // ----------------------------------------
  // ready pulses once both aw and w are valid and no response is pending
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      accept_q <= 1'b0;
      aw_en    <= 1'b1;
    end
    else if (!accept_q && awvalid && wvalid && aw_en)
    begin
      accept_q <= 1'b1;
      aw_en    <= 1'b0;
    end
    else
    begin
      accept_q <= 1'b0;
      // response taken, next write may start
      if (bvalid && bready)
        aw_en <= 1'b1;
    end
  end

  // bvalid follows the register update by one cycle, held until bready
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      bvalid <= 1'b0;
    else if (wr_en)
      bvalid <= 1'b1;
    else if (bready)
      bvalid <= 1'b0;
  end

  // byte-merged register file
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (wstrb[b])
          regs[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  // ----------------------------------------
  // triangle packing
  // ----------------------------------------
  // field positions follow the register map
  always_comb
  begin
    packed_tri.v1.x  = regs[0][8:0];
    packed_tri.v1.y  = regs[0][23:16];
    packed_tri.v1.z  = regs[1][15:0];
    packed_tri.v2.x  = regs[1][24:16];
    packed_tri.v2.y  = regs[2][7:0];
    packed_tri.v2.z  = regs[2][31:16];
    packed_tri.v3.x  = regs[3][8:0];
    packed_tri.v3.y  = regs[3][23:16];
    packed_tri.v3.z  = regs[4][15:0];
    packed_tri.color = regs[4][23:16];
  end

  // push lands one cycle after the write, dropped silently when full
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      tri_push <= 1'b0;
    else
      tri_push <= push_now;
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (push_now)
      tri_data <= packed_tri;
  end

  // ----------------------------------------
  // read channel
  // ----------------------------------------
  // no new address is taken while read data waits for rready
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      arready <= !arready && arvalid && !rvalid;
      if (arready && arvalid)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (arready && arvalid)
      rdata <= regs[araddr[4:2]];
  end

  // a response only ever follows a completed aw and w handshake
  a_bvalid_after_write: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
    else $error("bvalid rose with no accepted write");

  // the full flag seen at the write still holds when the push arrives
  a_no_push_when_full: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    tri_push |-> !fifo_full)
    else $error("triangle pushed into a full fifo");

endmodule

//--- common/axi_regs_pkg.sv
package axi_regs_pkg;

  // byte address, 8 words of 4 bytes
  typedef logic [4:0] axi_addr_t;

  // bus word and its byte lanes
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;

  // word index, taken from address bits 4..2
  typedef logic [2:0] reg_index_t;

  // bresp / rresp encoding
  typedef logic [1:0] axi_resp_t;

  // only OKAY is ever returned
  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

//--- common/raster_config.svh
`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

// ----------------------------------------
// display geometry
// ----------------------------------------
`define RASTER_H_RES 320
`define RASTER_V_RES 240
// one byte per pixel, h_res * v_res
`define RASTER_FB_DEPTH 76800

// ----------------------------------------
// triangle queue and clear values
// ----------------------------------------
`define TRI_FIFO_DEPTH 16
// black in RGB332
`define FB_CLEAR_COLOR 0
// farthest depth, so any plotted vertex passes the first test
`define ZBUF_CLEAR_DEPTH 255

// ----------------------------------------
// register map
// ----------------------------------------
// a write here submits registers 0 to 4 as one triangle
`define REG_PUSH_INDEX 5
`define REG_COUNT 8

`endif

//--- common/raster_pkg.sv
`include "raster_config.svh"

package raster_pkg;

  // ----------------------------------------
  // scalar widths
  // ----------------------------------------
  // column 0..319 needs 9 bits, row 0..239 fits in 8
  typedef logic [8:0]  coord_x_t;
  typedef logic [7:0]  coord_y_t;
  // z as submitted over the bus
  typedef logic [15:0] depth_t;
  // only the low byte of z is kept in the depth buffer
  typedef logic [7:0]  zbuf_depth_t;
  // RGB332
  typedef logic [7:0]  color_t;
  // linear index into either buffer
  typedef logic [16:0] pix_addr_t;

  // ----------------------------------------
  // triangle record
  // ----------------------------------------
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    depth_t   z;
  } vertex_t;

  typedef struct packed {
    vertex_t v1;
    vertex_t v2;
    vertex_t v3;
    color_t  color;
  } triangle_t;

  // draw controller states
  typedef enum logic [1:0] {
    clear_buf,
    wait_tri,
    plot_read,
    plot_write
  } ctrl_state_t;

  // row major address, y * h_res + x
  function automatic pix_addr_t pix_addr(coord_x_t x, coord_y_t y);
    return pix_addr_t'(y * `RASTER_H_RES + x);
  endfunction

endpackage

//--- draw/draw_controller.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module draw_controller (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  logic                    vsync,
  input  raster_pkg::triangle_t   tri_in,
  input  logic                    empty,
  input  raster_pkg::zbuf_depth_t rd_depth,
  output logic                    pop,
  output logic                    fb_we,
  output logic                    zb_we,
  output raster_pkg::pix_addr_t   wr_addr,
  output raster_pkg::color_t      wr_color,
  output raster_pkg::zbuf_depth_t wr_depth,
  output raster_pkg::pix_addr_t   rd_addr
);

  import raster_pkg::*;

  ctrl_state_t state;
  logic        vsync_meta;
  logic        vsync_sync;
  logic        vsync_prev;
  logic        vsync_rise;
  pix_addr_t   clear_addr;
  triangle_t   tri_q;
  logic [1:0]  vtx_sel;
  vertex_t     cur_v;
  logic        cur_in_range;
  pix_addr_t   cur_addr;
  logic        fwd_hit;
  zbuf_depth_t fwd_depth;
  zbuf_depth_t stored_depth;
  logic        depth_pass;

  // ----------------------------------------
  // vsync synchronizer and edge detect
  // ----------------------------------------
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      vsync_meta <= 1'b0;
      vsync_sync <= 1'b0;
      vsync_prev <= 1'b0;
    end
    else
    begin
      vsync_meta <= vsync;
      vsync_sync <= vsync_meta;
      vsync_prev <= vsync_sync;
    end
  end

  assign vsync_rise = vsync_sync && !vsync_prev;

  // ----------------------------------------
  // current vertex and depth test
  // ----------------------------------------
  always_comb
  begin
    case (vtx_sel)
      2'd0:    cur_v = tri_q.v1;
      2'd1:    cur_v = tri_q.v2;
      default: cur_v = tri_q.v3;
    endcase
  end

  assign cur_in_range = (cur_v.x < `RASTER_H_RES) && (cur_v.y < `RASTER_V_RES);
  assign cur_addr     = pix_addr(cur_v.x, cur_v.y);
  // depth read is issued during plot_read, data arrives in plot_write
  assign rd_addr      = cur_addr;
  // a write still in flight to the same pixel wins over the memory copy
  assign stored_depth = fwd_hit ? fwd_depth : rd_depth;
  assign depth_pass   = cur_v.z[7:0] < stored_depth;

  // ----------------------------------------
  // control FSM
  // ----------------------------------------
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      state      <= clear_buf;
      clear_addr <= '0;
      vtx_sel    <= '0;
      pop        <= 1'b0;
      fb_we      <= 1'b0;
      zb_we      <= 1'b0;
      fwd_hit    <= 1'b0;
    end
    else
    begin
      pop   <= 1'b0;
      fb_we <= 1'b0;
      zb_we <= 1'b0;
      case (state)
        clear_buf:
        begin
          // one pixel of each buffer per cycle
          fb_we      <= 1'b1;
          zb_we      <= 1'b1;
          clear_addr <= clear_addr + 1'b1;
          if (clear_addr == pix_addr_t'(`RASTER_FB_DEPTH - 1))
          begin
            clear_addr <= '0;
            state      <= wait_tri;
          end
        end
        wait_tri:
        begin
          // new frame takes priority over queued triangles
          if (vsync_rise)
            state <= clear_buf;
          else if (!empty)
          begin
            pop     <= 1'b1;
            vtx_sel <= '0;
            state   <= plot_read;
          end
        end
        plot_read:
        begin
          fwd_hit <= zb_we && (wr_addr == cur_addr);
          // off-screen vertices are skipped in one cycle
          if (cur_in_range)
            state <= plot_write;
          else if (vtx_sel == 2'd2)
            state <= wait_tri;
          else
            vtx_sel <= vtx_sel + 1'b1;
        end
        plot_write:
        begin
          fb_we   <= depth_pass;
          zb_we   <= depth_pass;
          vtx_sel <= vtx_sel + 1'b1;
          state   <= (vtx_sel == 2'd2) ? wait_tri : plot_read;
        end
        default:
          state <= clear_buf;
      endcase
    end
  end

  // write payload, qualified by the enables above
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == clear_buf)
    begin
      wr_addr  <= clear_addr;
      wr_color <= color_t'(`FB_CLEAR_COLOR);
      wr_depth <= zbuf_depth_t'(`ZBUF_CLEAR_DEPTH);
    end
    else
    begin
      wr_addr  <= cur_addr;
      wr_color <= tri_q.color;
      wr_depth <= cur_v.z[7:0];
    end
    // head of the fifo is held for the whole triangle
    if (state == wait_tri && !empty)
      tri_q <= tri_in;
    fwd_depth <= wr_depth;
  end

  a_wr_addr_range: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (fb_we || zb_we) |-> (wr_addr < `RASTER_FB_DEPTH))
    else $error("buffer write outside the frame");

endmodule

//--- draw/pixel_store.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module pixel_store (
  input  logic                    S_AXI_ACLK,
  input  logic                    fb_we,
  input  logic                    zb_we,
  input  raster_pkg::pix_addr_t   wr_addr,
  input  raster_pkg::color_t      wr_color,
  input  raster_pkg::zbuf_depth_t wr_depth,
  input  raster_pkg::pix_addr_t   rd_addr,
  input  logic [9:0]              draw_x,
  input  logic [9:0]              draw_y,
  output raster_pkg::zbuf_depth_t rd_depth,
  output logic [3:0]              red,
  output logic [3:0]              green,
  output logic [3:0]              blue
);

  import raster_pkg::*;

  color_t      fb_mem [`RASTER_FB_DEPTH];
  zbuf_depth_t zb_mem [`RASTER_FB_DEPTH];
  pix_addr_t   scan_addr;
  color_t      scan_pix;

  // ----------------------------------------
  // frame buffer, draw port in, scanout port out
  // ----------------------------------------
  // 640x480 timing shows each stored pixel as a 2x2 block
  assign scan_addr = pix_addr(draw_x[9:1], draw_y[8:1]);

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (fb_we)
      fb_mem[wr_addr] <= wr_color;
    scan_pix <= fb_mem[scan_addr];
  end

  // ----------------------------------------
  // depth buffer
  // ----------------------------------------
  // registered read, old value returned on a same-cycle write
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (zb_we)
      zb_mem[wr_addr] <= wr_depth;
    rd_depth <= zb_mem[rd_addr];
  end

  // RGB332 widened to 4 bits per channel, low bits zero
  assign red   = {scan_pix[7:5], 1'b0};
  assign green = {scan_pix[4:2], 1'b0};
  assign blue  = {scan_pix[1:0], 2'b00};

endmodule

//--- sim.f
+incdir+common
common/axi_regs_pkg.sv
common/raster_pkg.sv
source/tri_fifo.sv
axi/axi_reg_bank.sv
draw/pixel_store.sv
draw/draw_controller.sv
source/raster_top.sv
tests/raster_tb.sv

//--- source/raster_top.sv
`timescale 1ns/1ps

module raster_top (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  // write address / data
  input  axi_regs_pkg::axi_addr_t s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  axi_regs_pkg::axi_data_t s_axi_wdata,
  input  axi_regs_pkg::axi_strb_t s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  // write response
  output axi_regs_pkg::axi_resp_t s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  // read address / data
  input  axi_regs_pkg::axi_addr_t s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output axi_regs_pkg::axi_data_t s_axi_rdata,
  output axi_regs_pkg::axi_resp_t s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  // video side
  input  logic                    vsync,
  input  logic [9:0]              draw_x,
  input  logic [9:0]              draw_y,
  output logic [3:0]              red,
  output logic [3:0]              green,
  output logic [3:0]              blue
);

  import raster_pkg::*;

  // register bank -> fifo
  triangle_t   tri_data;
  logic        tri_push;
  logic        fifo_full;
  // fifo -> controller
  triangle_t   tri_out;
  logic        fifo_empty;
  logic        tri_pop;
  // controller <-> pixel store
  logic        fb_we;
  logic        zb_we;
  pix_addr_t   wr_addr;
  color_t      wr_color;
  zbuf_depth_t wr_depth;
  pix_addr_t   rd_addr;
  zbuf_depth_t rd_depth;

  axi_reg_bank i_axi_reg_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bresp         (s_axi_bresp),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .fifo_full     (fifo_full),
    .tri_push      (tri_push),
    .tri_data      (tri_data)
  );

  tri_fifo i_tri_fifo (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .push          (tri_push),
    .din           (tri_data),
    .pop           (tri_pop),
    .dout          (tri_out),
    .full          (fifo_full),
    .empty         (fifo_empty)
  );

  draw_controller i_draw_controller (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .vsync         (vsync),
    .tri_in        (tri_out),
    .empty         (fifo_empty),
    .rd_depth      (rd_depth),
    .pop           (tri_pop),
    .fb_we         (fb_we),
    .zb_we         (zb_we),
    .wr_addr       (wr_addr),
    .wr_color      (wr_color),
    .wr_depth      (wr_depth),
    .rd_addr       (rd_addr)
  );

  pixel_store i_pixel_store (
    .S_AXI_ACLK (S_AXI_ACLK),
    .fb_we      (fb_we),
    .zb_we      (zb_we),
    .wr_addr    (wr_addr),
    .wr_color   (wr_color),
    .wr_depth   (wr_depth),
    .rd_addr    (rd_addr),
    .draw_x     (draw_x),
    .draw_y     (draw_y),
    .rd_depth   (rd_depth),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

endmodule

//--- source/tri_fifo.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module tri_fifo #(
  parameter int DEPTH = `TRI_FIFO_DEPTH
) (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic                  push,
  input  raster_pkg::triangle_t din,
  input  logic                  pop,
  output raster_pkg::triangle_t dout,
  output logic                  full,
  output logic                  empty
);

  import raster_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  triangle_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // guard the pointers even if a caller misbehaves
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  // head entry, shown without a pop
  assign dout  = mem[rd_ptr];

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  a_no_pop_empty: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN) pop |-> !empty)
    else $error("pop from an empty triangle fifo");

  a_no_push_full: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN) push |-> !full)
    else $error("push into a full triangle fifo");

endmodule

//--- tests/raster_tb.sv
`timescale 1ns/1ps
`include "raster_config.svh"

module raster_tb;

  import raster_pkg::*;
  import axi_regs_pkg::*;

  // ----------------------------------------
  // timing and table types
  // ----------------------------------------
  localparam int NUM_CASES  = 4;
  // one full clear of both buffers plus slack
  localparam int CLEAR_WAIT = `RASTER_FB_DEPTH + 50;
  // a triangle plots in at most 8 cycles
  localparam int PLOT_WAIT  = 50;
  // three full clears with room for bus and plot traffic, 400000 cycles
  localparam int TIMEOUT_CYCLES = 3 * `RASTER_FB_DEPTH + 169600;
  localparam axi_resp_t OKAY_RESP = 2'b00;

  // sampled pixel and its expected {red, green, blue}
  typedef struct packed {
    coord_x_t    x;
    coord_y_t    y;
    logic [11:0] rgb;
  } sample_t;

  typedef struct packed {
    logic          vsync_first;
    triangle_t     shape;
    sample_t [2:0] samples;
  } case_t;

  logic        S_AXI_ACLK;
  logic        S_AXI_ARESETN;
  axi_addr_t   s_axi_awaddr;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  axi_data_t   s_axi_wdata;
  axi_strb_t   s_axi_wstrb;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  axi_resp_t   s_axi_bresp;
  logic        s_axi_bvalid;
  logic        s_axi_bready;
  axi_addr_t   s_axi_araddr;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  axi_data_t   s_axi_rdata;
  axi_resp_t   s_axi_rresp;
  logic        s_axi_rvalid;
  logic        s_axi_rready;
  logic        vsync;
  logic [9:0]  draw_x;
  logic [9:0]  draw_y;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;

  case_t       cases [NUM_CASES];
  string       case_names [NUM_CASES];
  logic [31:0] rng_state;
  int          error_count;
  int          check_count;
  int          cycle_count;

  raster_top i_raster_top (.*);

  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // strobed lanes take the new byte, the rest keep the old one
  function automatic axi_data_t byte_merge(axi_data_t old_word, axi_data_t new_word,
                                           axi_strb_t strb);
    axi_data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++)
    begin
      if (strb[b])
        merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  function automatic vertex_t vertex_at(int x, int y, depth_t z);
    vertex_t v;
    v.x = coord_x_t'(x);
    v.y = coord_y_t'(y);
    v.z = z;
    return v;
  endfunction

  function automatic triangle_t build_triangle(vertex_t v1, vertex_t v2, vertex_t v3,
                                               color_t color);
    triangle_t t;
    t.v1    = v1;
    t.v2    = v2;
    t.v3    = v3;
    t.color = color;
    return t;
  endfunction

  function automatic sample_t pixel_sample(int x, int y, logic [11:0] rgb);
    sample_t s;
    s.x   = coord_x_t'(x);
    s.y   = coord_y_t'(y);
    s.rgb = rgb;
    return s;
  endfunction

  task compare(input string name, input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // ----------------------------------------
  // bus tasks, outputs read as they stood before the edge
  // ----------------------------------------
  task bus_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                 input string name);
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
    do
      @(posedge S_AXI_ACLK);
    while (!s_axi_awready);
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    do
      @(posedge S_AXI_ACLK);
    while (!s_axi_bvalid);
    compare({name, " bresp"}, 32'(OKAY_RESP), 32'(s_axi_bresp));
  endtask

  task bus_read(input axi_addr_t addr, output axi_data_t data, input string name);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    do
      @(posedge S_AXI_ACLK);
    while (!s_axi_arready);
    s_axi_arvalid <= 1'b0;
    do
      @(posedge S_AXI_ACLK);
    while (!s_axi_rvalid);
    data = s_axi_rdata;
    compare({name, " rresp"}, 32'(OKAY_RESP), 32'(s_axi_rresp));
  endtask

  // full word, then a random word under random strobes, then read back
  task check_regs();
    axi_data_t first;
    axi_data_t second;
    axi_data_t got;
    axi_strb_t strb;
    int        idx;
    for (int k = 0; k < `REG_COUNT; k++)
    begin
      // register 5 first, so its pushes carry reset values, a black dot at the origin
      idx       = (k + `REG_PUSH_INDEX) % `REG_COUNT;
      rng_state = xorshift32(rng_state);
      first     = rng_state;
      rng_state = xorshift32(rng_state);
      second    = rng_state;
      rng_state = xorshift32(rng_state);
      strb      = rng_state[3:0];
      bus_write(axi_addr_t'(idx * 4), first, 4'hF, $sformatf("reg%0d", idx));
      bus_write(axi_addr_t'(idx * 4), second, strb, $sformatf("reg%0d", idx));
      bus_read(axi_addr_t'(idx * 4), got, $sformatf("reg%0d", idx));
      compare($sformatf("reg%0d readback", idx), byte_merge(first, second, strb), got);
    end
  endtask

  // register words laid out per the register map, then the push write
  task submit_triangle(input triangle_t t, input string name);
    axi_data_t words [5];
    words[0] = {8'h00, t.v1.y, 7'h00, t.v1.x};
    words[1] = {7'h00, t.v2.x, t.v1.z};
    words[2] = {t.v2.z, 8'h00, t.v2.y};
    words[3] = {8'h00, t.v3.y, 7'h00, t.v3.x};
    words[4] = {8'h00, t.color, t.v3.z};
    for (int i = 0; i < 5; i++)
      bus_write(axi_addr_t'(i * 4), words[i], 4'hF, name);
    bus_write(axi_addr_t'(`REG_PUSH_INDEX * 4), 32'h0, 4'hF, name);
    repeat (PLOT_WAIT) @(posedge S_AXI_ACLK);
  endtask

  // scanout doubles each pixel, color is registered one cycle after the address
  task check_pixel(input sample_t s, input logic [11:0] expected, input string name);
    draw_x <= {s.x, 1'b0};
    draw_y <= {1'b0, s.y, 1'b0};
    repeat (2) @(posedge S_AXI_ACLK);
    compare($sformatf("%s (%0d,%0d)", name, s.x, s.y), 32'(expected),
            32'({red, green, blue}));
  endtask

  task pulse_vsync();
    vsync <= 1'b1;
    repeat (4) @(posedge S_AXI_ACLK);
    vsync <= 1'b0;
    repeat (CLEAR_WAIT) @(posedge S_AXI_ACLK);
  endtask

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  // expected rgb is RGB332 widened with zero low bits
  task load_table();
    case_names[0]        = "plot_basic";
    cases[0].vsync_first = 1'b0;
    cases[0].shape       = build_triangle(vertex_at(10, 20, 16'h0080),
                             vertex_at(100, 50, 16'h0140), vertex_at(319, 239, 16'h0010), 8'hE5);
    cases[0].samples[0]  = pixel_sample(10, 20, 12'hE24);
    cases[0].samples[1]  = pixel_sample(100, 50, 12'hE24);
    cases[0].samples[2]  = pixel_sample(319, 239, 12'hE24);
    // x of 400 would wrap onto (80,31) and x of 330 onto (10,101) if drawn
    case_names[1]        = "offscreen_skip";
    cases[1].vsync_first = 1'b0;
    cases[1].shape       = build_triangle(vertex_at(400, 30, 16'h0020),
                             vertex_at(50, 60, 16'h0030), vertex_at(330, 100, 16'h0030), 8'h1A);
    cases[1].samples[0]  = pixel_sample(50, 60, 12'h0C8);
    cases[1].samples[1]  = pixel_sample(80, 31, 12'h000);
    cases[1].samples[2]  = pixel_sample(10, 101, 12'h000);
    // closer z wins, equal low byte and farther z leave the pixel
    case_names[2]        = "depth_test";
    cases[2].vsync_first = 1'b0;
    cases[2].shape       = build_triangle(vertex_at(10, 20, 16'h0040),
                             vertex_at(100, 50, 16'h0050), vertex_at(319, 239, 16'h0110), 8'h03);
    cases[2].samples[0]  = pixel_sample(10, 20, 12'h00C);
    cases[2].samples[1]  = pixel_sample(100, 50, 12'hE24);
    cases[2].samples[2]  = pixel_sample(319, 239, 12'hE24);
    // redraw of (10,20) with a farther z needs the cleared depth buffer
    case_names[3]        = "after_vsync";
    cases[3].vsync_first = 1'b1;
    cases[3].shape       = build_triangle(vertex_at(5, 5, 16'h0001),
                             vertex_at(200, 100, 16'h0002), vertex_at(10, 20, 16'h00F0), 8'hFF);
    cases[3].samples[0]  = pixel_sample(5, 5, 12'hEEC);
    cases[3].samples[1]  = pixel_sample(200, 100, 12'hEEC);
    cases[3].samples[2]  = pixel_sample(10, 20, 12'hEEC);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    rng_state     = 32'h2d3c;
    error_count   = 0;
    check_count   = 0;
    S_AXI_ARESETN <= 1'b0;
    s_axi_awaddr  <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_wvalid  <= 1'b0;
    s_axi_bready  <= 1'b1;
    s_axi_araddr  <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b1;
    vsync         <= 1'b0;
    draw_x        <= '0;
    draw_y        <= '0;
    load_table();
    repeat (10) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    // register traffic overlaps the clear after reset
    check_regs();
    repeat (CLEAR_WAIT) @(posedge S_AXI_ACLK);
    for (int c = 0; c < NUM_CASES; c++)
    begin
      for (int s = 0; s < 3; s++)
        check_pixel(cases[c].samples[s], 12'h000, "reset_clear");
    end
    for (int c = 0; c < NUM_CASES; c++)
    begin
      if (cases[c].vsync_first)
      begin
        pulse_vsync();
        // everything drawn before the new frame is black again
        for (int p = 0; p < c; p++)
        begin
          for (int s = 0; s < 3; s++)
            check_pixel(cases[p].samples[s], 12'h000, "vsync_clear");
        end
      end
      submit_triangle(cases[c].shape, case_names[c]);
      for (int s = 0; s < 3; s++)
        check_pixel(cases[c].samples[s], cases[c].samples[s].rgb, case_names[c]);
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge S_AXI_ACLK);
      cycle_count++;
    end
    $display("Timeout: the test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule
